/* design/mau_pkg.sv */
package mau_pkg;

	//******************************
	// Widths and sizes
	//******************************
	localparam int DATA_W      = 32;
	localparam int SEL_W       = DATA_W / 8;
	localparam int DISP_W      = 4;
	localparam int QUEUE_DEPTH = 4;
	localparam int PTR_W       = $clog2(QUEUE_DEPTH);

	typedef logic [DATA_W-1:0] word_t;

	// Bit 3 is the lane at offset 0 (bits 31:24)
	typedef logic [SEL_W-1:0]  sel_t;

	typedef logic [DISP_W-1:0] disp_t;

	//******************************
	// Access encodings
	//******************************
	typedef enum logic {
		ACC_LOAD  = 1'b0,
		ACC_STORE = 1'b1
	} acc_op_e;

	typedef enum logic [1:0] {
		SZ_BYTE = 2'b00,
		SZ_WORD = 2'b01,
		SZ_LONG = 2'b10
	} acc_size_e;

	// Bus master states
	typedef enum logic {
		BUS_IDLE   = 1'b0,
		BUS_ACTIVE = 1'b1
	} bus_state_e;

	// One queued memory access
	typedef struct packed {
		acc_op_e   op;
		acc_size_e size;
		word_t     addr;
		word_t     wdata;
		sel_t      sel;
	} access_req_t;

endpackage

/* design/access_if.sv */
`timescale 1ns/1ps

interface access_if;
	import mau_pkg::*;

	logic        valid;
	logic        ready;
	access_req_t payload;

	// Payload held stable while valid and not ready
	modport source (
		output valid,
		output payload,
		input  ready
	);

	modport sink (
		input  valid,
		input  payload,
		output ready
	);

endinterface

/* design/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  mau_pkg::acc_op_e   cmd_op,
	input  mau_pkg::acc_size_e cmd_size,
	input  mau_pkg::word_t     cmd_base,
	input  mau_pkg::disp_t     cmd_disp,
	input  mau_pkg::word_t     cmd_wdata,
	access_if.source           req
);
	import mau_pkg::*;

	word_t scaled_disp;
	word_t eff_addr;
	word_t store_data;
	sel_t  lane_sel;

	//******************************
	// Address
	//******************************
	// Displacement counts in units of the access size
	always_comb begin
		case (cmd_size)
			SZ_BYTE: scaled_disp = word_t'(cmd_disp);
			SZ_WORD: scaled_disp = word_t'({cmd_disp, 1'b0});
			default: scaled_disp = word_t'({cmd_disp, 2'b00});
		endcase
	end

	assign eff_addr = cmd_base + scaled_disp;

	//******************************
	// Store lanes
	//******************************
	always_comb begin
		if (cmd_op == ACC_STORE) begin
			case (cmd_size)
				SZ_BYTE: store_data = {4{cmd_wdata[7:0]}};
				SZ_WORD: store_data = {2{cmd_wdata[15:0]}};
				default: store_data = cmd_wdata;
			endcase
		end else begin
			store_data = '0;
		end
	end

	// Big-endian lanes, offset 0 is the top byte
	always_comb begin
		case (cmd_size)
			SZ_BYTE: lane_sel = 4'b1000 >> eff_addr[1:0];
			SZ_WORD: lane_sel = eff_addr[1] ? 4'b0011 : 4'b1100;
			default: lane_sel = 4'b1111;
		endcase
	end

	//******************************
	// Output register
	//******************************
	assign cmd_ready = !req.valid || req.ready;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			req.valid <= 1'b0;
		end else if (cmd_ready) begin
			req.valid <= cmd_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (cmd_valid && cmd_ready) begin
			req.payload <= '{op: cmd_op, size: cmd_size, addr: eff_addr,
			                 wdata: store_data, sel: lane_sel};
		end
	end

endmodule

/* design/access_queue.sv */
`timescale 1ns/1ps

module access_queue (
	input  logic     CLK,
	input  logic     RST_N,
	access_if.sink   in,
	access_if.source out
);
	import mau_pkg::*;

	access_req_t      entries [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	// A full queue still accepts when the head leaves this cycle
	assign in.ready    = !full || out.ready;
	assign out.valid   = (count != '0);
	assign out.payload = entries[rd_ptr];

	//******************************
	// Pointers and count
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end

			if (pop) begin
				if (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//******************************
	// Storage
	//******************************
	always_ff @(posedge CLK) begin
		if (push) begin
			entries[wr_ptr] <= in.payload;
		end
	end

endmodule

/* design/wb_access.sv */
`timescale 1ns/1ps

module wb_access (
	input  logic           CLK,
	input  logic           RST_N,
	access_if.sink         req,
	output logic           wb_cyc,
	output logic           wb_stb,
	output logic           wb_we,
	output mau_pkg::word_t wb_adr,
	output mau_pkg::word_t wb_dat_o,
	output mau_pkg::sel_t  wb_sel,
	input  mau_pkg::word_t wb_dat_i,
	input  logic           wb_ack,
	output logic           result_valid,
	output mau_pkg::word_t result_data
);
	import mau_pkg::*;

	bus_state_e  state;
	access_req_t cur;
	logic        active;
	logic        accept;
	logic [1:0]  lane_shift;
	word_t       shifted;
	word_t       load_data;

	assign active    = (state == BUS_ACTIVE);
	assign req.ready = (state == BUS_IDLE);
	assign accept    = req.valid && req.ready;

	//******************************
	// FSM
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state        <= BUS_IDLE;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			case (state)
				BUS_IDLE: begin
					if (req.valid) begin
						state <= BUS_ACTIVE;
					end
				end
				BUS_ACTIVE: begin
					if (wb_ack) begin
						state        <= BUS_IDLE;
						result_valid <= (cur.op == ACC_LOAD);
					end
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	// Latched request drives the bus for the whole cycle
	always_ff @(posedge CLK) begin
		if (accept) begin
			cur <= req.payload;
		end
	end

	//******************************
	// Wishbone outputs
	//******************************
	assign wb_cyc   = active;
	assign wb_stb   = active;
	assign wb_we    = active && (cur.op == ACC_STORE);
	assign wb_adr   = cur.addr;
	assign wb_dat_o = cur.wdata;
	assign wb_sel   = cur.sel;

	//******************************
	// Load alignment
	//******************************
	// Bytes to move the addressed lane down to bit 0
	always_comb begin
		case (cur.size)
			SZ_BYTE: lane_shift = ~cur.addr[1:0];
			SZ_WORD: lane_shift = {~cur.addr[1], 1'b0};
			default: lane_shift = 2'b00;
		endcase
	end

	assign shifted = wb_dat_i >> {lane_shift, 3'b000};

	always_comb begin
		case (cur.size)
			SZ_BYTE: load_data = {{24{shifted[7]}}, shifted[7:0]};
			SZ_WORD: load_data = {{16{shifted[15]}}, shifted[15:0]};
			default: load_data = shifted;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (active && wb_ack && (cur.op == ACC_LOAD)) begin
			result_data <= load_data;
		end
	end

endmodule

/* design/mem_access_top.sv */
`timescale 1ns/1ps

module mem_access_top (
	input  logic               CLK,
	input  logic               RST_N,

	// Command side
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  mau_pkg::acc_op_e   cmd_op,
	input  mau_pkg::acc_size_e cmd_size,
	input  mau_pkg::word_t     cmd_base,
	input  mau_pkg::disp_t     cmd_disp,
	input  mau_pkg::word_t     cmd_wdata,

	// Load results
	output logic               result_valid,
	output mau_pkg::word_t     result_data,

	// Wishbone master
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output mau_pkg::word_t     wb_adr,
	output mau_pkg::word_t     wb_dat_o,
	output mau_pkg::sel_t      wb_sel,
	input  mau_pkg::word_t     wb_dat_i,
	input  logic               wb_ack
);

	access_if gen_to_queue ();
	access_if queue_to_bus ();

	addr_gen u_addr_gen (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_op    (cmd_op),
		.cmd_size  (cmd_size),
		.cmd_base  (cmd_base),
		.cmd_disp  (cmd_disp),
		.cmd_wdata (cmd_wdata),
		.req       (gen_to_queue.source)
	);

	access_queue u_access_queue (
		.CLK   (CLK),
		.RST_N (RST_N),
		.in    (gen_to_queue.sink),
		.out   (queue_to_bus.source)
	);

	wb_access u_wb_access (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.req          (queue_to_bus.sink),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_o     (wb_dat_o),
		.wb_sel       (wb_sel),
		.wb_dat_i     (wb_dat_i),
		.wb_ack       (wb_ack),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

endmodule

/* bench/mem_access_checker.sv */
`timescale 1ns/1ps

module mem_access_checker (
	input  logic           CLK,
	input  logic           RST_N,
	input  logic           wb_cyc,
	input  logic           wb_stb,
	input  logic           wb_we,
	input  logic           wb_ack,
	input  mau_pkg::word_t wb_adr,
	input  mau_pkg::word_t wb_dat_o,
	input  mau_pkg::sel_t  wb_sel,
	input  logic           result_valid
);

	// Number of assertion failures so far
	int assert_fails = 0;

	//******************************
	// Wishbone classic rules
	//******************************
	a_stb_in_cyc : assert property (@(posedge CLK) disable iff (!RST_N)
		wb_stb |-> wb_cyc)
	else begin
		$error("wb_stb high outside a bus cycle");
		assert_fails++;
	end

	// Master holds its outputs until ack
	a_hold_until_ack : assert property (@(posedge CLK) disable iff (!RST_N)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_sel)
			&& $stable(wb_we) && $stable(wb_dat_o)))
	else begin
		$error("bus outputs changed while waiting for ack");
		assert_fails++;
	end

	//******************************
	// Result pulse
	//******************************
	a_result_pulse : assert property (@(posedge CLK) disable iff (!RST_N)
		result_valid |=> !result_valid)
	else begin
		$error("result_valid held for two cycles");
		assert_fails++;
	end

endmodule

/* bench/tb_mem_access.sv */
`timescale 1ns/1ps

module tb_mem_access;
	import mau_pkg::*;

	localparam int NUM_ROWS = 20;

	typedef struct packed {
		acc_op_e   op;
		acc_size_e size;
		word_t     base;
		disp_t     disp;
		word_t     wdata;
		word_t     exp_adr;
		sel_t      exp_sel;
		word_t     exp_dat;
		word_t     exp_res;
	} row_t;

	logic      CLK;
	logic      RST_N;
	logic      cmd_valid;
	logic      cmd_ready;
	acc_op_e   cmd_op;
	acc_size_e cmd_size;
	word_t     cmd_base;
	disp_t     cmd_disp;
	word_t     cmd_wdata;
	logic      result_valid;
	word_t     result_data;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	word_t     wb_adr;
	word_t     wb_dat_o;
	sel_t      wb_sel;
	word_t     wb_dat_i;
	logic      wb_ack;

	row_t        table_rows [NUM_ROWS];
	bit          row_bad [NUM_ROWS];
	word_t       mem [64];
	logic [31:0] lfsr_state = 32'h3abf_9e57;
	int          check_errors = 0;
	int          rows_done = 0;
	int          rows_failed = 0;
	int          bus_idx = 0;
	int          load_ptr = 0;
	logic        cyc_seen = 1'b0;
	logic        in_cycle = 1'b0;
	int          wait_left = 0;

	mem_access_top u_dut (.*);

	bind mem_access_top mem_access_checker u_checker (
		.CLK(CLK), .RST_N(RST_N), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel), .result_valid(result_valid)
	);

	always #50 CLK = ~CLK;

	//******************************
	// Helpers
	//******************************
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic bit lfsr_bit();
		bit fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic check_sel(input string name, input sel_t got, input sel_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic check_op(input string name, input acc_op_e got, input acc_op_e exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			check_errors++;
		end
	endtask

	task automatic set_row(input int idx, input acc_op_e op, input acc_size_e size,
		input word_t base, input disp_t disp, input word_t wdata, input word_t adr,
		input sel_t sel, input word_t dat, input word_t res);
		table_rows[idx] = '{op, size, base, disp, wdata, adr, sel, dat, res};
	endtask

	task automatic finish_row(input int idx);
		if (row_bad[idx]) begin
			rows_failed++;
			$display("row %0d: mismatch", idx);
		end else begin
			$display("row %0d: ok", idx);
		end
		rows_done++;
	endtask

	//******************************
	// Wishbone slave model
	//******************************
	always @(negedge CLK) begin
		if (wb_ack) begin
			wb_ack <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				wait_left = {lfsr_bit(), lfsr_bit()};
			end
			if (wait_left == 0) begin
				if (wb_we) begin
					for (int b = 0; b < 4; b++) begin
						if (wb_sel[b]) begin
							mem[wb_adr[7:2]][b*8 +: 8] = wb_dat_o[b*8 +: 8];
						end
					end
				end
				wb_dat_i <= mem[wb_adr[7:2]];
				wb_ack   <= 1'b1;
				in_cycle = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	//******************************
	// Monitors
	//******************************
	// Bus side, once at the start of each cycle
	always @(negedge CLK) begin
		int errs_before;
		errs_before = check_errors;
		if (RST_N && wb_cyc && !cyc_seen) begin
			if (bus_idx >= NUM_ROWS) begin
				$display("Bus cycle seen after all table rows were done");
				check_errors++;
			end else begin
				check_word("wb_adr", wb_adr, table_rows[bus_idx].exp_adr);
				check_sel("wb_sel", wb_sel, table_rows[bus_idx].exp_sel);
				check_op("wb_we", wb_we ? ACC_STORE : ACC_LOAD, table_rows[bus_idx].op);
				if (table_rows[bus_idx].op == ACC_STORE) begin
					check_word("wb_dat_o", wb_dat_o, table_rows[bus_idx].exp_dat);
				end
				if (check_errors != errs_before) begin
					row_bad[bus_idx] = 1'b1;
				end
				if (table_rows[bus_idx].op == ACC_STORE) begin
					finish_row(bus_idx);
				end
				bus_idx++;
			end
		end
		cyc_seen = wb_cyc;
	end

	// Load results, in table order
	always @(negedge CLK) begin
		int errs_before;
		errs_before = check_errors;
		if (RST_N && result_valid) begin
			while (load_ptr < NUM_ROWS && table_rows[load_ptr].op != ACC_LOAD) begin
				load_ptr++;
			end
			if (load_ptr >= NUM_ROWS || load_ptr >= bus_idx) begin
				$display("Load result arrived with no matching load on the bus");
				check_errors++;
			end else begin
				check_word("result_data", result_data, table_rows[load_ptr].exp_res);
				if (check_errors != errs_before) begin
					row_bad[load_ptr] = 1'b1;
				end
				finish_row(load_ptr);
				load_ptr++;
			end
		end
	end

	//******************************
	// Watchdog
	//******************************
	initial begin
		#((NUM_ROWS * 12 + 100) * 100);
		$display("Run timed out before all table rows finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	//******************************
	// Stimulus
	//******************************
	initial begin
		int reset_errs;
		CLK       = 1'b0;
		RST_N     = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = ACC_LOAD;
		cmd_size  = SZ_BYTE;
		cmd_base  = '0;
		cmd_disp  = '0;
		cmd_wdata = '0;
		wb_dat_i  = '0;
		wb_ack    = 1'b0;

		for (int i = 0; i < 64; i++) begin
			mem[i] = {i[7:0] ^ 8'h5a, i[7:0], ~i[7:0], i[7:0] ^ 8'hc3};
		end

		// Stores at every lane, then displacement scaling
		set_row(0, ACC_STORE, SZ_LONG, 32'h40, 4'd0, 32'h1122_3344,
			32'h40, 4'b1111, 32'h1122_3344, 32'h0);
		set_row(1, ACC_STORE, SZ_BYTE, 32'h50, 4'd0, 32'h1234_56ab,
			32'h50, 4'b1000, 32'habab_abab, 32'h0);
		set_row(2, ACC_STORE, SZ_BYTE, 32'h50, 4'd1, 32'h0000_007f,
			32'h51, 4'b0100, 32'h7f7f_7f7f, 32'h0);
		set_row(3, ACC_STORE, SZ_BYTE, 32'h50, 4'd2, 32'hffff_ff80,
			32'h52, 4'b0010, 32'h8080_8080, 32'h0);
		set_row(4, ACC_STORE, SZ_BYTE, 32'h50, 4'd3, 32'h0000_0001,
			32'h53, 4'b0001, 32'h0101_0101, 32'h0);
		set_row(5, ACC_STORE, SZ_WORD, 32'h60, 4'd0, 32'hdead_8123,
			32'h60, 4'b1100, 32'h8123_8123, 32'h0);
		set_row(6, ACC_STORE, SZ_WORD, 32'h60, 4'd1, 32'h0000_7ffe,
			32'h62, 4'b0011, 32'h7ffe_7ffe, 32'h0);
		set_row(7, ACC_STORE, SZ_BYTE, 32'h70, 4'd3, 32'h0000_005a,
			32'h73, 4'b0001, 32'h5a5a_5a5a, 32'h0);
		set_row(8, ACC_STORE, SZ_WORD, 32'h70, 4'd3, 32'h0000_c3c3,
			32'h76, 4'b0011, 32'hc3c3_c3c3, 32'h0);
		set_row(9, ACC_STORE, SZ_LONG, 32'h70, 4'd3, 32'h0bad_f00d,
			32'h7c, 4'b1111, 32'h0bad_f00d, 32'h0);

		// Loads back, signed and unsigned lanes
		set_row(10, ACC_LOAD, SZ_LONG, 32'h40, 4'd0, 32'h0,
			32'h40, 4'b1111, 32'h0, 32'h1122_3344);
		set_row(11, ACC_LOAD, SZ_BYTE, 32'h50, 4'd0, 32'h0,
			32'h50, 4'b1000, 32'h0, 32'hffff_ffab);
		set_row(12, ACC_LOAD, SZ_BYTE, 32'h50, 4'd1, 32'h0,
			32'h51, 4'b0100, 32'h0, 32'h0000_007f);
		set_row(13, ACC_LOAD, SZ_BYTE, 32'h50, 4'd2, 32'h0,
			32'h52, 4'b0010, 32'h0, 32'hffff_ff80);
		set_row(14, ACC_LOAD, SZ_BYTE, 32'h50, 4'd3, 32'h0,
			32'h53, 4'b0001, 32'h0, 32'h0000_0001);
		set_row(15, ACC_LOAD, SZ_WORD, 32'h60, 4'd0, 32'h0,
			32'h60, 4'b1100, 32'h0, 32'hffff_8123);
		set_row(16, ACC_LOAD, SZ_WORD, 32'h60, 4'd1, 32'h0,
			32'h62, 4'b0011, 32'h0, 32'h0000_7ffe);
		set_row(17, ACC_LOAD, SZ_LONG, 32'h70, 4'd3, 32'h0,
			32'h7c, 4'b1111, 32'h0, 32'h0bad_f00d);
		set_row(18, ACC_LOAD, SZ_WORD, 32'h70, 4'd3, 32'h0,
			32'h76, 4'b0011, 32'h0, 32'hffff_c3c3);
		set_row(19, ACC_LOAD, SZ_BYTE, 32'h70, 4'd3, 32'h0,
			32'h73, 4'b0001, 32'h0, 32'h0000_005a);

		// Reset state, held for 10 cycles
		repeat (10) begin
			@(negedge CLK);
			check_word("wb_cyc", word_t'(wb_cyc), 32'h0);
			check_word("wb_stb", word_t'(wb_stb), 32'h0);
			check_word("result_valid", word_t'(result_valid), 32'h0);
			check_word("cmd_ready", word_t'(cmd_ready), 32'h1);
		end
		RST_N = 1'b1;
		@(negedge CLK);
		check_word("wb_cyc", word_t'(wb_cyc), 32'h0);
		check_word("wb_stb", word_t'(wb_stb), 32'h0);
		check_word("result_valid", word_t'(result_valid), 32'h0);
		check_word("cmd_ready", word_t'(cmd_ready), 32'h1);
		reset_errs = check_errors;
		$display("reset state: %s", (reset_errs == 0) ? "ok" : "mismatch");

		// Back to back commands, held until accepted
		for (int i = 0; i < NUM_ROWS; i++) begin
			cmd_valid = 1'b1;
			cmd_op    = table_rows[i].op;
			cmd_size  = table_rows[i].size;
			cmd_base  = table_rows[i].base;
			cmd_disp  = table_rows[i].disp;
			cmd_wdata = table_rows[i].wdata;
			while (!cmd_ready) begin
				@(negedge CLK);
			end
			@(negedge CLK);
		end
		cmd_valid = 1'b0;

		wait (rows_done == NUM_ROWS);
		repeat (5) @(negedge CLK);

		$display("%0d rows passed, %0d rows failed, %0d check errors, %0d assertion failures",
			NUM_ROWS - rows_failed, rows_failed, check_errors,
			u_dut.u_checker.assert_fails);
		if (rows_failed == 0 && check_errors == 0
			&& u_dut.u_checker.assert_fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
design/mau_pkg.sv
design/access_if.sv
design/addr_gen.sv
design/access_queue.sv
design/wb_access.sv
design/mem_access_top.sv
bench/mem_access_checker.sv
bench/tb_mem_access.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
TOP       ?= tb_mem_access
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
